// ==== test/gpuMem_golden.txt ====
# kind p0 p1 p2 p3 p4 e0 e1 e2 e3, all hex
# TEXL   p0 line                              e0 low word, e1 high word
# CLUTR  p0 block                             e0 first beat data
# FILL   p0 block, p1 colour                  e0 every block word
# PAIR   p0 block, p1 pairId, p2 valid, p3 colorL, p4 colorR
#        e0 written word, e1 word before, e2 word after
# MIX    p0 fill block, p1 colour, p2 CLUT block, p3 texture line
#        e0 fill word, e1 CLUT first data, e2 texture low, e3 texture high
# CLUTLR p0 left block, p1 right block        e0 left first data, e1 right first data
# TEXLR  p0 left line, p1 right line          e0 e1 left low high, e2 e3 right low high
TEXL   00123 0 0 0 0 A5000246 A5000247 0 0
CLUTR  0041 0 0 0 0 A5000208 0 0 0
FILL   0100 BEEF 0 0 0 BEEFBEEF 0 0 0
PAIR   0200 5 2 1234 CAFE CAFE1005 A5001004 A5001006 0
MIX    0180 5A5A 0023 00200 0 5A5A5A5A A5000118 A5000400 A5000401
CLUTLR 0010 0011 0 0 0 A5000080 A5000088 0 0
TEXLR  00050 00051 0 0 0 A50000A0 A50000A1 A50000A2 A50000A3

// ==== files.f ====
+incdir+include
rtl/gpuMemPkg.sv
rtl/memBusArbiter.sv
rtl/cmdWriteEngine.sv
rtl/clutRefill.sv
rtl/texRefill.sv
rtl/gpuMemArbTop.sv
test/tbClockGen.sv
test/ddrModel.sv
test/tbGpuMem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the GPU memory arbiter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tbGpuMem \
	-o simGpuMem > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simGpuMem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0

// ==== test/tbGpuMem.sv ====
// GPU memory arbiter testbench
`timescale 1ns/1ps
`include "gpuMem_params.svh"

module tbGpuMem import gpuMemPkg::*; ();

	localparam int TIMEOUT = 200;	// Cycles per wait

	logic                        gpuClk, resetX;
	memCmdT                      cmdWord;
	logic                        cmdBusy;
	logic                        clutReqL, clutReqR, clutDoneL, clutDoneR, clutWrite;
	logic [`GPU_CLUT_ADR_W-1:0]  clutAdrL, clutAdrR;
	logic [`GPU_CLUT_IDX_W-1:0]  clutIndex;
	logic [`GPU_MEM_DAT_W-1:0]   clutData;
	logic                        texReqL, texReqR, texDoneL, texDoneR, texWrite;
	logic [`GPU_TEX_ADR_W-1:0]   texAdrL, texAdrR, texAdr;
	logic [2*`GPU_MEM_DAT_W-1:0] texData;
	logic [`GPU_MEM_ADR_W-1:0]   memAdr, peekAdr;
	logic [`GPU_MEM_DAT_W-1:0]   memDatW, memDatR, peekDat;
	logic [`GPU_MEM_CNT_W-1:0]   memCnt;
	logic [3:0]                  memSel;
	logic                        memWrt, memReq, memAck, memBusy;

	int mismatchCnt = 0;
	int otherErrCnt = 0;
	int clutDoneCntL = 0, clutDoneCntR = 0, texDoneCntL = 0, texDoneCntR = 0;
	time clutEndTime, texEndTime, cmdEndTime;

	// Observed cache writes
	logic [`GPU_CLUT_IDX_W-1:0]  clutIdxQ[$];
	logic [`GPU_MEM_DAT_W-1:0]   clutDatQ[$];
	logic [1:0]                  clutDoneQ[$];
	logic [`GPU_TEX_ADR_W-1:0]   texAdrQ[$];
	logic [2*`GPU_MEM_DAT_W-1:0] texDatQ[$];
	logic [1:0]                  texDoneQ[$];

	tbClockGen clkGen (.gpuClk_o(gpuClk), .resetX_o(resetX));

	gpuMemArbTop dut_i (
		.gpuClk(gpuClk), .resetX(resetX), .cmdWord_i(cmdWord), .cmdBusy_o(cmdBusy),
		.clutReqL_i(clutReqL), .clutAdrL_i(clutAdrL), .clutReqR_i(clutReqR),
		.clutAdrR_i(clutAdrR), .clutDoneL_o(clutDoneL), .clutDoneR_o(clutDoneR),
		.clutWrite_o(clutWrite), .clutIndex_o(clutIndex), .clutData_o(clutData),
		.texReqL_i(texReqL), .texAdrL_i(texAdrL), .texReqR_i(texReqR), .texAdrR_i(texAdrR),
		.texDoneL_o(texDoneL), .texDoneR_o(texDoneR), .texWrite_o(texWrite),
		.texAdr_o(texAdr), .texData_o(texData),
		.memAdr_o(memAdr), .memDat_o(memDatW), .memDat_i(memDatR), .memCnt_o(memCnt),
		.memSel_o(memSel), .memWrt_o(memWrt), .memReq_o(memReq), .memAck_i(memAck),
		.memBusy_o(memBusy)
	);

	ddrModel vram (
		.gpuClk(gpuClk), .resetX_i(resetX), .memAdr_i(memAdr), .memDat_i(memDatW),
		.memDat_o(memDatR), .memCnt_i(memCnt), .memSel_i(memSel), .memWrt_i(memWrt),
		.memReq_i(memReq), .memAck_o(memAck), .peekAdr_i(peekAdr), .peekDat_o(peekDat)
	);

	// ----------------------------------------
	// Monitor, sampled mid-cycle
	// ----------------------------------------
	always @(negedge gpuClk) begin
		if (!resetX) begin
			if (memAck && memBusy !== 1'b1) begin
				otherErrCnt++;
				$display("Memory acked at %0t while the bus was not marked busy", $time);
			end
			if (clutWrite) begin
				clutIdxQ.push_back(clutIndex);
				clutDatQ.push_back(clutData);
				clutDoneQ.push_back({clutDoneR, clutDoneL});
			end
			if (clutDoneL) clutDoneCntL++;
			if (clutDoneR) clutDoneCntR++;
			if (clutDoneL || clutDoneR) clutEndTime = $time;
			if (texWrite) begin
				texAdrQ.push_back(texAdr);
				texDatQ.push_back(texData);
				texDoneQ.push_back({texDoneR, texDoneL});
				texEndTime = $time;
			end
			if (texDoneL) texDoneCntL++;
			if (texDoneR) texDoneCntR++;
		end
	end

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic checkClut(input logic [`GPU_CLUT_IDX_W-1:0] gotIdx, expIdx,
			input logic [`GPU_MEM_DAT_W-1:0] gotDat, expDat, input logic [1:0] gotDone, expDone);
		if (gotIdx !== expIdx || gotDat !== expDat || gotDone !== expDone) begin
			mismatchCnt++;
			$display("MISMATCH at %0t: CLUT write idx %h data %h done %b, expected %h %h %b",
				$time, gotIdx, gotDat, gotDone, expIdx, expDat, expDone);
		end
	endtask

	task automatic checkTex(input logic [`GPU_TEX_ADR_W-1:0] gotAdr, expAdr,
			input logic [2*`GPU_MEM_DAT_W-1:0] gotLine, expLine,
			input logic [1:0] gotDone, expDone);
		if (gotAdr !== expAdr || gotLine !== expLine || gotDone !== expDone) begin
			mismatchCnt++;
			$display("MISMATCH at %0t: texture line %h data %h done %b, expected %h %h %b",
				$time, gotAdr, gotLine, gotDone, expAdr, expLine, expDone);
		end
	endtask

	task automatic checkWord(input logic [`GPU_MEM_ADR_W-1:0] adr,
			input logic [`GPU_MEM_DAT_W-1:0] expDat);
		peekAdr = adr;
		#1;
		if (peekDat !== expDat) begin
			mismatchCnt++;
			$display("MISMATCH at %0t: memory word %h is %h, expected %h",
				$time, adr, peekDat, expDat);
		end
	endtask

	// ----------------------------------------
	// Stimulus tasks
	// ----------------------------------------
	task automatic runCmd(input memCmdE op, input logic [`GPU_CLUT_ADR_W-1:0] blk,
			input logic [2:0] pid, input logic [1:0] vp, input logic [15:0] colL, colR);
		memCmdT w;
		int t;
		w = '0;
		w.opcode = op;
		w.blockAdr = blk;
		w.pairId = pid;
		w.validPair = vp;
		w.colorL = colL;
		w.colorR = colR;
		cmdWord = w;
		@(posedge gpuClk);
		#1;
		cmdWord = '0;	// Single-cycle strobe
		t = 0;
		while (cmdBusy && t < TIMEOUT) begin
			@(posedge gpuClk);
			#1;
			t++;
		end
		if (cmdBusy) begin
			otherErrCnt++;
			$display("Timeout: command writer stayed busy at %0t", $time);
		end
		cmdEndTime = $time;
	endtask

	// Cache holds its miss level until the complete pulse
	task automatic clutMiss(input logic sideR, input logic [`GPU_CLUT_ADR_W-1:0] blk);
		int startCnt;
		int t;
		startCnt = sideR ? clutDoneCntR : clutDoneCntL;
		if (sideR) begin
			clutAdrR = blk;
			clutReqR = 1'b1;
		end else begin
			clutAdrL = blk;
			clutReqL = 1'b1;
		end
		t = 0;
		while ((sideR ? clutDoneCntR : clutDoneCntL) == startCnt && t < TIMEOUT) begin
			@(posedge gpuClk);
			#1;
			t++;
		end
		if (t >= TIMEOUT) begin
			otherErrCnt++;
			$display("Timeout: CLUT miss on side %0d never completed", sideR);
		end
		if (sideR) clutReqR = 1'b0;
		else clutReqL = 1'b0;
	endtask

	task automatic texMiss(input logic sideR, input logic [`GPU_TEX_ADR_W-1:0] line);
		int startCnt;
		int t;
		startCnt = sideR ? texDoneCntR : texDoneCntL;
		if (sideR) begin
			texAdrR = line;
			texReqR = 1'b1;
		end else begin
			texAdrL = line;
			texReqL = 1'b1;
		end
		t = 0;
		while ((sideR ? texDoneCntR : texDoneCntL) == startCnt && t < TIMEOUT) begin
			@(posedge gpuClk);
			#1;
			t++;
		end
		if (t >= TIMEOUT) begin
			otherErrCnt++;
			$display("Timeout: texture miss on side %0d never completed", sideR);
		end
		if (sideR) texReqR = 1'b0;
		else texReqL = 1'b0;
	endtask

	// Eight writes, index from block low bits and beat
	task automatic expectClutBurst(input logic [`GPU_CLUT_ADR_W-1:0] blk,
			input logic [`GPU_MEM_DAT_W-1:0] firstDat, input logic sideR);
		logic [1:0] expDone;
		for (int beat = 0; beat < `GPU_FILL_BEATS; beat++) begin
			expDone = (beat == `GPU_FILL_BEATS - 1) ? (sideR ? 2'b10 : 2'b01) : 2'b00;
			if (clutIdxQ.size() == 0) begin
				otherErrCnt++;
				$display("CLUT write %0d of block %h never appeared", beat, blk);
			end else begin
				checkClut(clutIdxQ.pop_front(), {blk[3:0], 3'(beat)},
					clutDatQ.pop_front(), firstDat + 32'(beat), clutDoneQ.pop_front(), expDone);
			end
		end
	endtask

	task automatic expectTexLine(input logic [`GPU_TEX_ADR_W-1:0] line,
			input logic [`GPU_MEM_DAT_W-1:0] lo, hi, input logic sideR);
		if (texDatQ.size() == 0) begin
			otherErrCnt++;
			$display("Texture line write never appeared");
		end else begin
			checkTex(texAdrQ.pop_front(), line, texDatQ.pop_front(), {hi, lo},
				texDoneQ.pop_front(), sideR ? 2'b10 : 2'b01);
		end
	endtask

	task automatic expectFill(input logic [`GPU_CLUT_ADR_W-1:0] blk,
			input logic [`GPU_MEM_DAT_W-1:0] expDat);
		for (int i = 0; i < `GPU_FILL_BEATS; i++) begin
			checkWord({blk, 3'(i), 2'b00}, expDat);
		end
	endtask

	task automatic syncDrive();
		@(posedge gpuClk);
		#1;
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		int fd;
		int n;
		int t;
		string line;
		string kind;
		logic [31:0] p0, p1, p2, p3, p4, e0, e1, e2, e3;
		cmdWord = '0;
		clutReqL = 1'b0;
		clutReqR = 1'b0;
		clutAdrL = '0;
		clutAdrR = '0;
		texReqL = 1'b0;
		texReqR = 1'b0;
		texAdrL = '0;
		texAdrR = '0;
		peekAdr = '0;
		t = 0;
		while (resetX !== 1'b0 && t < TIMEOUT) begin
			@(posedge gpuClk);
			t++;
		end
		if (resetX !== 1'b0) begin
			otherErrCnt++;
			$display("Timeout: reset never released");
		end
		fd = $fopen("test/gpuMem_golden.txt", "r");
		if (fd == 0) begin
			otherErrCnt++;
			$display("Could not open the golden stimulus file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line.substr(0, 0) == "#") continue;
				n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
					kind, p0, p1, p2, p3, p4, e0, e1, e2, e3);
				if (n != 10) begin
					otherErrCnt++;
					$display("Malformed golden line: %s", line);
					continue;
				end
				syncDrive();
				case (kind)
				"TEXL": begin
					texMiss(1'b0, p0[16:0]);
					expectTexLine(p0[16:0], e0, e1, 1'b0);
				end
				"CLUTR": begin
					clutMiss(1'b1, p0[14:0]);
					expectClutBurst(p0[14:0], e0, 1'b1);
				end
				"FILL": begin
					runCmd(CMD_FILL, p0[14:0], 3'd0, 2'b00, p1[15:0], 16'h0);
					expectFill(p0[14:0], e0);
				end
				"PAIR": begin
					runCmd(CMD_PIXEL2VRAM, p0[14:0], p1[2:0], p2[1:0], p3[15:0], p4[15:0]);
					checkWord({p0[14:0], p1[2:0], 2'b00}, e0);
					checkWord({p0[14:0], p1[2:0] - 3'd1, 2'b00}, e1);
					checkWord({p0[14:0], p1[2:0] + 3'd1, 2'b00}, e2);
				end
				"MIX": begin
					fork
						runCmd(CMD_FILL, p0[14:0], 3'd0, 2'b00, p1[15:0], 16'h0);
						clutMiss(1'b0, p2[14:0]);
						texMiss(1'b0, p3[16:0]);
					join
					expectFill(p0[14:0], e0);
					expectClutBurst(p2[14:0], e1, 1'b0);
					expectTexLine(p3[16:0], e2, e3, 1'b0);
					if (texEndTime <= clutEndTime || texEndTime <= cmdEndTime) begin
						otherErrCnt++;
						$display("Texture line arrived before the other masters finished");
					end
				end
				"CLUTLR": begin
					fork
						clutMiss(1'b0, p0[14:0]);
						clutMiss(1'b1, p1[14:0]);
					join
					expectClutBurst(p0[14:0], e0, 1'b0);	// Left served first
					expectClutBurst(p1[14:0], e1, 1'b1);
				end
				"TEXLR": begin
					fork
						texMiss(1'b0, p0[16:0]);
						texMiss(1'b1, p1[16:0]);
					join
					expectTexLine(p0[16:0], e0, e1, 1'b0);
					expectTexLine(p1[16:0], e2, e3, 1'b1);
				end
				default: begin
					otherErrCnt++;
					$display("Unknown operation in golden file: %s", kind);
				end
				endcase
				// Bus released once every master is done
				t = 0;
				while (memBusy !== 1'b0 && t < TIMEOUT) begin
					@(posedge gpuClk);
					#1;
					t++;
				end
				if (memBusy !== 1'b0) begin
					otherErrCnt++;
					$display("Timeout: memory bus still granted after %s", kind);
				end
				if (clutIdxQ.size() != 0 || texDatQ.size() != 0) begin
					otherErrCnt++;
					$display("Unexpected extra cache writes after %s", kind);
					clutIdxQ.delete();
					clutDatQ.delete();
					clutDoneQ.delete();
					texAdrQ.delete();
					texDatQ.delete();
					texDoneQ.delete();
				end
			end
			$fclose(fd);
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatchCnt, otherErrCnt);
		if (mismatchCnt == 0 && otherErrCnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== test/ddrModel.sv ====
// Behavioural video memory
`timescale 1ns/1ps
`include "gpuMem_params.svh"

module ddrModel (
	input  logic                      gpuClk,
	input  logic                      resetX_i,
	input  logic [`GPU_MEM_ADR_W-1:0] memAdr_i,
	input  logic [`GPU_MEM_DAT_W-1:0] memDat_i,	// Write data
	output logic [`GPU_MEM_DAT_W-1:0] memDat_o,	// Read data
	input  logic [`GPU_MEM_CNT_W-1:0] memCnt_i,
	input  logic [3:0]                memSel_i,
	input  logic                      memWrt_i,
	input  logic                      memReq_i,
	output logic                      memAck_o,
	input  logic [`GPU_MEM_ADR_W-1:0] peekAdr_i,	// Testbench read-back
	output logic [`GPU_MEM_DAT_W-1:0] peekDat_o
);

	localparam int WORDS = 262144;

	logic [`GPU_MEM_DAT_W-1:0] mem [0:WORDS-1];

	assign memDat_o  = mem[memAdr_i[`GPU_MEM_ADR_W-1:2]];	// Valid in ack cycle
	assign peekDat_o = mem[peekAdr_i[`GPU_MEM_ADR_W-1:2]];

	// ----------------------------------------
	// Burst responder
	// ----------------------------------------
	initial begin
		int delay;
		int cnt;
		int wordIdx;
		void'($urandom(61329));	// One seed for the whole run
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = {8'hA5, 24'(i)};	// Word address under A5 tag
		end
		memAck_o = 1'b0;
		forever begin
			@(posedge gpuClk);
			#1;
			if (!resetX_i && memReq_i) begin
				delay = int'($urandom % 4);	// Start delay 0..3
				repeat (delay) begin
					@(posedge gpuClk);
					#1;
				end
				cnt = int'(memCnt_i);
				for (int beat = 0; beat <= cnt; beat++) begin
					memAck_o = 1'b1;
					@(negedge gpuClk);	// Master bus stable here
					if (memWrt_i) begin
						wordIdx = int'(memAdr_i[`GPU_MEM_ADR_W-1:2]);
						for (int b = 0; b < 4; b++) begin
							if (memSel_i[b]) mem[wordIdx][8*b +: 8] = memDat_i[8*b +: 8];
						end
					end
					@(posedge gpuClk);
					#1;
					memAck_o = 1'b0;
					if (beat < cnt && ($urandom % 4) == 0) begin	// Occasional gap
						@(posedge gpuClk);
						#1;
					end
				end
			end
		end
	end

endmodule

// ==== test/tbClockGen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tbClockGen (
	output logic gpuClk_o,
	output logic resetX_o
);

	initial begin
		gpuClk_o = 1'b0;
		forever #10 gpuClk_o = ~gpuClk_o;	// 20 ns period
	end

	// Reset high for two rising edges
	initial begin
		resetX_o = 1'b1;
		repeat (2) @(posedge gpuClk_o);
		#1 resetX_o = 1'b0;
	end

endmodule

// ==== rtl/gpuMemArbTop.sv ====
// GPU memory arbiter top level
`timescale 1ns/1ps
`include "gpuMem_params.svh"

module gpuMemArbTop import gpuMemPkg::*; (
	input  logic                         gpuClk,
	input  logic                         resetX,
	// Command side
	input  memCmdT                       cmdWord_i,
	output logic                         cmdBusy_o,
	// CLUT cache
	input  logic                         clutReqL_i,
	input  logic [`GPU_CLUT_ADR_W-1:0]   clutAdrL_i,
	input  logic                         clutReqR_i,
	input  logic [`GPU_CLUT_ADR_W-1:0]   clutAdrR_i,
	output logic                         clutDoneL_o,
	output logic                         clutDoneR_o,
	output logic                         clutWrite_o,
	output logic [`GPU_CLUT_IDX_W-1:0]   clutIndex_o,
	output logic [`GPU_MEM_DAT_W-1:0]    clutData_o,
	// Texture cache
	input  logic                         texReqL_i,
	input  logic [`GPU_TEX_ADR_W-1:0]    texAdrL_i,
	input  logic                         texReqR_i,
	input  logic [`GPU_TEX_ADR_W-1:0]    texAdrR_i,
	output logic                         texDoneL_o,
	output logic                         texDoneR_o,
	output logic                         texWrite_o,
	output logic [`GPU_TEX_ADR_W-1:0]    texAdr_o,
	output logic [2*`GPU_MEM_DAT_W-1:0]  texData_o,
	// Video memory bus
	output logic [`GPU_MEM_ADR_W-1:0]    memAdr_o,
	output logic [`GPU_MEM_DAT_W-1:0]    memDat_o,
	input  logic [`GPU_MEM_DAT_W-1:0]    memDat_i,
	output logic [`GPU_MEM_CNT_W-1:0]    memCnt_o,
	output logic [3:0]                   memSel_o,
	output logic                         memWrt_o,
	output logic                         memReq_o,
	input  logic                         memAck_i,
	output logic                         memBusy_o
);

	// ----------------------------------------
	// Master to arbiter wires
	// ----------------------------------------
	logic                      cmdReq, cmdWrt, cmdAck;
	logic [`GPU_MEM_CNT_W-1:0] cmdCnt;
	logic [`GPU_MEM_ADR_W-1:0] cmdAdr;
	logic [`GPU_MEM_DAT_W-1:0] cmdDat;
	logic [3:0]                cmdSel;
	logic                      clutReq, clutAck;
	logic [`GPU_MEM_CNT_W-1:0] clutCnt;
	logic [`GPU_MEM_ADR_W-1:0] clutAdr;
	logic                      texReq, texAck;
	logic [`GPU_MEM_CNT_W-1:0] texCnt;
	logic [`GPU_MEM_ADR_W-1:0] texAdr;

	cmdWriteEngine cmdWriter (
		.gpuClk(gpuClk), .resetX(resetX), .cmdWord_i(cmdWord_i), .ack_i(cmdAck),
		.cmdBusy_o(cmdBusy_o), .req_o(cmdReq), .cnt_o(cmdCnt), .adr_o(cmdAdr),
		.dat_o(cmdDat), .sel_o(cmdSel), .wrt_o(cmdWrt)
	);

	clutRefill clutMaster (
		.gpuClk(gpuClk), .resetX(resetX),
		.clutReqL_i(clutReqL_i), .clutAdrL_i(clutAdrL_i),
		.clutReqR_i(clutReqR_i), .clutAdrR_i(clutAdrR_i),
		.ack_i(clutAck), .memDat_i(memDat_i),
		.clutDoneL_o(clutDoneL_o), .clutDoneR_o(clutDoneR_o), .clutWrite_o(clutWrite_o),
		.clutIndex_o(clutIndex_o), .clutData_o(clutData_o),
		.req_o(clutReq), .cnt_o(clutCnt), .adr_o(clutAdr)
	);

	texRefill texMaster (
		.gpuClk(gpuClk), .resetX(resetX),
		.texReqL_i(texReqL_i), .texAdrL_i(texAdrL_i),
		.texReqR_i(texReqR_i), .texAdrR_i(texAdrR_i),
		.ack_i(texAck), .memDat_i(memDat_i),
		.texDoneL_o(texDoneL_o), .texDoneR_o(texDoneR_o), .texWrite_o(texWrite_o),
		.texAdr_o(texAdr_o), .texData_o(texData_o),
		.req_o(texReq), .cnt_o(texCnt), .adr_o(texAdr)
	);

	// Refill masters only read, data and write tied off
	memBusArbiter arbiter (
		.gpuClk(gpuClk), .resetX(resetX),
		.cmdReq_i(cmdReq), .cmdCnt_i(cmdCnt), .cmdAdr_i(cmdAdr),
		.cmdDat_i(cmdDat), .cmdSel_i(cmdSel), .cmdWrt_i(cmdWrt), .cmdAck_o(cmdAck),
		.clutReq_i(clutReq), .clutCnt_i(clutCnt), .clutAdr_i(clutAdr),
		.clutDat_i('0), .clutSel_i(4'hF), .clutWrt_i(1'b0), .clutAck_o(clutAck),
		.texReq_i(texReq), .texCnt_i(texCnt), .texAdr_i(texAdr),
		.texDat_i('0), .texSel_i(4'hF), .texWrt_i(1'b0), .texAck_o(texAck),
		.memAdr_o(memAdr_o), .memDat_o(memDat_o), .memCnt_o(memCnt_o),
		.memSel_o(memSel_o), .memWrt_o(memWrt_o), .memReq_o(memReq_o),
		.memAck_i(memAck_i), .memBusy_o(memBusy_o)
	);

endmodule

// ==== rtl/texRefill.sv ====
// Texture cache refill master
`timescale 1ns/1ps
`include "gpuMem_params.svh"

module texRefill import gpuMemPkg::*; (
	input  logic                         gpuClk,
	input  logic                         resetX,
	input  logic                         texReqL_i,
	input  logic [`GPU_TEX_ADR_W-1:0]    texAdrL_i,
	input  logic                         texReqR_i,
	input  logic [`GPU_TEX_ADR_W-1:0]    texAdrR_i,
	input  logic                         ack_i,
	input  logic [`GPU_MEM_DAT_W-1:0]    memDat_i,
	output logic                         texDoneL_o,
	output logic                         texDoneR_o,
	output logic                         texWrite_o,
	output logic [`GPU_TEX_ADR_W-1:0]    texAdr_o,
	output logic [2*`GPU_MEM_DAT_W-1:0]  texData_o,
	output logic                         req_o,
	output logic [`GPU_MEM_CNT_W-1:0]    cnt_o,
	output logic [`GPU_MEM_ADR_W-1:0]    adr_o
);

	refillStateE               texState;
	logic                      texSideR;	// Served side, 1 is right
	logic                      texBeat;	// Second beat flag
	logic [`GPU_TEX_ADR_W-1:0] texLineAdr;
	logic [`GPU_MEM_DAT_W-1:0] texFirst;	// Low half of the line

	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			texState <= RS_IDLE;
			texSideR <= 1'b0;
			texBeat  <= 1'b0;
		end else begin
			case (texState)
			RS_IDLE: begin
				texBeat <= 1'b0;
				if (texReqL_i | texReqR_i) begin
					texSideR <= !texReqL_i;	// Left first
					texState <= RS_READ;
				end
			end
			RS_READ: begin
				if (ack_i) begin
					texBeat <= 1'b1;
					if (texBeat) texState <= RS_HOLD;
				end
			end
			default: texState <= RS_IDLE;
			endcase
		end
	end

	// Line address and first beat
	always_ff @(posedge gpuClk) begin
		if (texState == RS_IDLE) texLineAdr <= texReqL_i ? texAdrL_i : texAdrR_i;
		if (req_o && ack_i && !texBeat) texFirst <= memDat_i;
	end

	assign req_o  = (texState == RS_READ);
	assign cnt_o  = `GPU_MEM_CNT_W'(`GPU_TEX_BEATS - 1);
	assign adr_o  = {texLineAdr, texBeat, 2'b00};

	// Whole line on second ack
	assign texWrite_o = ack_i & req_o & texBeat;
	assign texAdr_o   = texLineAdr;
	assign texData_o  = {memDat_i, texFirst};
	assign texDoneL_o = texWrite_o & !texSideR;
	assign texDoneR_o = texWrite_o & texSideR;

endmodule

// ==== rtl/clutRefill.sv ====
// CLUT cache refill master
`timescale 1ns/1ps
`include "gpuMem_params.svh"

module clutRefill import gpuMemPkg::*; (
	input  logic                       gpuClk,
	input  logic                       resetX,
	input  logic                       clutReqL_i,
	input  logic [`GPU_CLUT_ADR_W-1:0] clutAdrL_i,
	input  logic                       clutReqR_i,
	input  logic [`GPU_CLUT_ADR_W-1:0] clutAdrR_i,
	input  logic                       ack_i,
	input  logic [`GPU_MEM_DAT_W-1:0]  memDat_i,
	output logic                       clutDoneL_o,
	output logic                       clutDoneR_o,
	output logic                       clutWrite_o,
	output logic [`GPU_CLUT_IDX_W-1:0] clutIndex_o,
	output logic [`GPU_MEM_DAT_W-1:0]  clutData_o,
	output logic                       req_o,
	output logic [`GPU_MEM_CNT_W-1:0]  cnt_o,
	output logic [`GPU_MEM_ADR_W-1:0]  adr_o
);

	localparam logic [`GPU_MEM_CNT_W-1:0] CLUT_LAST = `GPU_MEM_CNT_W'(`GPU_FILL_BEATS - 1);

	refillStateE                clutState;
	logic                       clutSideR;	// Served side, 1 is right
	logic [`GPU_MEM_CNT_W-1:0]  clutBeat;
	logic [`GPU_CLUT_ADR_W-1:0] clutBlkAdr;
	logic                       clutLast;

	assign clutLast = (clutBeat == CLUT_LAST);

	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			clutState <= RS_IDLE;
			clutSideR <= 1'b0;
			clutBeat  <= '0;
		end else begin
			case (clutState)
			RS_IDLE: begin
				clutBeat <= '0;
				if (clutReqL_i | clutReqR_i) begin
					clutSideR <= !clutReqL_i;	// Left first
					clutState <= RS_READ;
				end
			end
			RS_READ: begin
				if (ack_i) begin
					clutBeat <= clutBeat + 1'b1;
					if (clutLast) clutState <= RS_HOLD;
				end
			end
			default: clutState <= RS_IDLE;	// Hold ends after one cycle
			endcase
		end
	end

	// Block address of the served side
	always_ff @(posedge gpuClk) begin
		if (clutState == RS_IDLE) clutBlkAdr <= clutReqL_i ? clutAdrL_i : clutAdrR_i;
	end

	assign req_o  = (clutState == RS_READ);
	assign cnt_o  = CLUT_LAST;
	assign adr_o  = {clutBlkAdr, clutBeat, 2'b00};

	// Cache write per beat
	assign clutWrite_o = ack_i & req_o;
	assign clutIndex_o = {clutBlkAdr[3:0], clutBeat};
	assign clutData_o  = memDat_i;
	assign clutDoneL_o = clutWrite_o & clutLast & !clutSideR;	// With eighth write
	assign clutDoneR_o = clutWrite_o & clutLast & clutSideR;

	// Memory acks only inside the burst
	ackInBurst: assert property (@(posedge gpuClk) disable iff (resetX)
		ack_i |-> req_o);

endmodule

// ==== rtl/cmdWriteEngine.sv ====
// Command writer bus master
`timescale 1ns/1ps
`include "gpuMem_params.svh"

module cmdWriteEngine import gpuMemPkg::*; (
	input  logic                      gpuClk,
	input  logic                      resetX,
	input  memCmdT                    cmdWord_i,
	input  logic                      ack_i,
	output logic                      cmdBusy_o,
	output logic                      req_o,
	output logic [`GPU_MEM_CNT_W-1:0] cnt_o,
	output logic [`GPU_MEM_ADR_W-1:0] adr_o,
	output logic [`GPU_MEM_DAT_W-1:0] dat_o,
	output logic [3:0]                sel_o,
	output logic                      wrt_o
);

	localparam logic [`GPU_MEM_CNT_W-1:0] FILL_LAST = `GPU_MEM_CNT_W'(`GPU_FILL_BEATS - 1);

	cmdStateE                   cmdState;
	logic [`GPU_MEM_CNT_W-1:0]  cmdBeat;	// Fill beat number
	logic [15:0]                cmdColL;
	logic [15:0]                cmdColR;
	logic [1:0]                 cmdValid;
	logic [2:0]                 cmdPairId;
	logic [`GPU_CLUT_ADR_W-1:0] cmdBlkAdr;
	logic                       cmdStrobe;
	logic                       cmdLast;

	assign cmdStrobe = (cmdWord_i.opcode != CMD_NONE) && (cmdState == CS_IDLE);
	assign cmdLast   = (cmdState == CS_FILL) ? (cmdBeat == FILL_LAST) : 1'b1;

	// ----------------------------------------
	// Control FSM
	// ----------------------------------------
	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			cmdState <= CS_IDLE;
			cmdBeat  <= '0;
		end else begin
			case (cmdState)
			CS_IDLE: begin
				cmdBeat <= '0;
				if (cmdStrobe) begin
					case (cmdWord_i.opcode)
					CMD_PIXEL2VRAM: cmdState <= CS_PAIR;
					CMD_FILL:       cmdState <= CS_FILL;
					default:        cmdState <= CS_IDLE;	// Unknown opcode dropped
					endcase
				end
			end
			CS_PAIR, CS_FILL: begin
				if (ack_i) begin
					cmdBeat <= cmdBeat + 1'b1;
					if (cmdLast) cmdState <= CS_IDLE;	// Busy falls here
				end
			end
			default: cmdState <= CS_IDLE;
			endcase
		end
	end

	// Payload latched on strobe
	always_ff @(posedge gpuClk) begin
		if (cmdStrobe) begin
			cmdColL   <= cmdWord_i.colorL;
			cmdBlkAdr <= cmdWord_i.blockAdr;
			cmdPairId <= cmdWord_i.pairId;
			if (cmdWord_i.opcode == CMD_FILL) begin
				cmdColR  <= cmdWord_i.colorL;	// Same colour both halves
				cmdValid <= 2'b11;
			end else begin
				cmdColR  <= cmdWord_i.colorR;
				cmdValid <= cmdWord_i.validPair;
			end
		end
	end

	// ----------------------------------------
	// Master bus
	// ----------------------------------------
	assign cmdBusy_o = (cmdState != CS_IDLE);
	assign req_o     = cmdBusy_o;	// One burst per command
	assign wrt_o     = cmdBusy_o;
	assign cnt_o     = (cmdState == CS_FILL) ? FILL_LAST : '0;
	assign adr_o     = (cmdState == CS_FILL) ? {cmdBlkAdr, cmdBeat, 2'b00}
	                                         : {cmdBlkAdr, cmdPairId, 2'b00};
	assign dat_o     = {cmdColR, cmdColL};	// Right pixel high
	assign sel_o     = {cmdValid[1], cmdValid[1], cmdValid[0], cmdValid[0]};

endmodule

// ==== rtl/memBusArbiter.sv ====
// Fixed-priority memory bus arbiter
`timescale 1ns/1ps
`include "gpuMem_params.svh"

module memBusArbiter import gpuMemPkg::*; (
	input  logic                      gpuClk,
	input  logic                      resetX,
	// Command writer
	input  logic                      cmdReq_i,
	input  logic [`GPU_MEM_CNT_W-1:0] cmdCnt_i,
	input  logic [`GPU_MEM_ADR_W-1:0] cmdAdr_i,
	input  logic [`GPU_MEM_DAT_W-1:0] cmdDat_i,
	input  logic [3:0]                cmdSel_i,
	input  logic                      cmdWrt_i,
	output logic                      cmdAck_o,
	// CLUT refill
	input  logic                      clutReq_i,
	input  logic [`GPU_MEM_CNT_W-1:0] clutCnt_i,
	input  logic [`GPU_MEM_ADR_W-1:0] clutAdr_i,
	input  logic [`GPU_MEM_DAT_W-1:0] clutDat_i,
	input  logic [3:0]                clutSel_i,
	input  logic                      clutWrt_i,
	output logic                      clutAck_o,
	// Texture refill
	input  logic                      texReq_i,
	input  logic [`GPU_MEM_CNT_W-1:0] texCnt_i,
	input  logic [`GPU_MEM_ADR_W-1:0] texAdr_i,
	input  logic [`GPU_MEM_DAT_W-1:0] texDat_i,
	input  logic [3:0]                texSel_i,
	input  logic                      texWrt_i,
	output logic                      texAck_o,
	// Memory side
	output logic [`GPU_MEM_ADR_W-1:0] memAdr_o,
	output logic [`GPU_MEM_DAT_W-1:0] memDat_o,
	output logic [`GPU_MEM_CNT_W-1:0] memCnt_o,
	output logic [3:0]                memSel_o,
	output logic                      memWrt_o,
	output logic                      memReq_o,
	input  logic                      memAck_i,
	output logic                      memBusy_o
);

	arbGrantE grant;
	logic     grantedReq;	// Req of the current owner

	// ----------------------------------------
	// Grant register
	// ----------------------------------------
	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			grant <= GNT_NONE;
		end else if (grant == GNT_NONE) begin
			// Command >> CLUT >> texture
			if (cmdReq_i)       grant <= GNT_CMD;
			else if (clutReq_i) grant <= GNT_CLUT;
			else if (texReq_i)  grant <= GNT_TEX;
		end else if (!grantedReq) begin
			grant <= GNT_NONE;	// Burst over
		end
	end

	// ----------------------------------------
	// Bus multiplexer
	// ----------------------------------------
	always_comb begin
		grantedReq = 1'b0;
		memAdr_o   = '0;
		memDat_o   = '0;
		memCnt_o   = '0;
		memSel_o   = '0;
		memWrt_o   = 1'b0;
		case (grant)
		GNT_CMD: begin
			grantedReq = cmdReq_i;
			memAdr_o   = cmdAdr_i;
			memDat_o   = cmdDat_i;
			memCnt_o   = cmdCnt_i;
			memSel_o   = cmdSel_i;
			memWrt_o   = cmdWrt_i;
		end
		GNT_CLUT: begin
			grantedReq = clutReq_i;
			memAdr_o   = clutAdr_i;
			memDat_o   = clutDat_i;
			memCnt_o   = clutCnt_i;
			memSel_o   = clutSel_i;
			memWrt_o   = clutWrt_i;
		end
		GNT_TEX: begin
			grantedReq = texReq_i;
			memAdr_o   = texAdr_i;
			memDat_o   = texDat_i;
			memCnt_o   = texCnt_i;
			memSel_o   = texSel_i;
			memWrt_o   = texWrt_i;
		end
		default: ;	// Idle bus
		endcase
	end

	assign memReq_o  = grantedReq;	// Low in the decision cycle
	assign memBusy_o = (grant != GNT_NONE);

	// Ack back to owner only
	assign cmdAck_o  = memAck_i & (grant == GNT_CMD);
	assign clutAck_o = memAck_i & (grant == GNT_CLUT);
	assign texAck_o  = memAck_i & (grant == GNT_TEX);

	// Every memory ack reaches exactly one owner
	ackOwner: assert property (@(posedge gpuClk) disable iff (resetX)
		memAck_i |-> $onehot({cmdAck_o, clutAck_o, texAck_o}));

	// Owner drops req only after its last ack
	reqAfterAck: assert property (@(posedge gpuClk) disable iff (resetX)
		$fell(grantedReq) |-> $past(memAck_i));

endmodule

// ==== rtl/gpuMemPkg.sv ====
// GPU memory arbiter types
`include "gpuMem_params.svh"

package gpuMemPkg;

	// Command opcodes, nonzero means strobe
	typedef enum logic [2:0] {
		CMD_NONE       = 3'd0,
		CMD_PIXEL2VRAM = 3'd1,	// One masked pixel pair
		CMD_FILL       = 3'd2	// Eight beats of one colour
	} memCmdE;

	// Command word, first field is the top end
	typedef struct packed {
		logic [15:0]                colorL;
		logic [15:0]                colorR;
		logic [1:0]                 validPair;	// Bit 1 right, bit 0 left
		logic [`GPU_CLUT_ADR_W-1:0] blockAdr;	// 32-byte block
		logic [2:0]                 pairId;	// Pair inside the block
		logic                       rsvd;
		memCmdE                     opcode;
	} memCmdT;

	// Command writer FSM
	typedef enum logic [1:0] {
		CS_IDLE,
		CS_PAIR,
		CS_FILL
	} cmdStateE;

	// Refill master FSM
	typedef enum logic [1:0] {
		RS_IDLE,
		RS_READ,
		RS_HOLD	// One cycle for the cache to drop its level
	} refillStateE;

	// Arbiter grant
	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_CMD,
		GNT_CLUT,
		GNT_TEX
	} arbGrantE;

endpackage

// ==== include/gpuMem_params.svh ====
// GPU memory arbiter widths
`ifndef GPU_MEM_PARAMS_SVH
`define GPU_MEM_PARAMS_SVH

// ----------------------------------------
// Shared memory bus
// ----------------------------------------
`define GPU_MEM_ADR_W	20	// Byte address, 1 MB of VRAM
`define GPU_MEM_DAT_W	32	// One beat
`define GPU_MEM_CNT_W	3	// Beats minus one

// ----------------------------------------
// Cache side
// ----------------------------------------
`define GPU_TEX_ADR_W	17	// 8-byte line index
`define GPU_CLUT_ADR_W	15	// 32-byte block index
`define GPU_CLUT_IDX_W	7	// Four block bits plus beat number
`define GPU_CMD_W	56	// Command word from GPU

`define GPU_FILL_BEATS	8	// One 32-byte block
`define GPU_TEX_BEATS	2	// One 8-byte line

`endif
